// ==== dmem_wb_pkg.sv ====
/* Shared widths, codes and payload types for the data-memory Wishbone port.
   Referenced by scoped name from the bridge, FIFO users and the RAM. */

`default_nettype none

package dmem_wb_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int WB_WIDTH  = 32;
    localparam int SEL_WIDTH = 4;

    // Core command codes
    localparam logic MEM_CMD_RD = 1'b0;
    localparam logic MEM_CMD_WR = 1'b1;

    // Core access width codes
    localparam logic [1:0] MEM_WIDTH_BYTE  = 2'b00;
    localparam logic [1:0] MEM_WIDTH_HWORD = 2'b01;
    localparam logic [1:0] MEM_WIDTH_WORD  = 2'b10;

    // Response codes back to the core
    localparam logic [1:0] MEM_RESP_NOTRDY = 2'b00;
    localparam logic [1:0] MEM_RESP_RDY_OK = 2'b01;
    localparam logic [1:0] MEM_RESP_RDY_ER = 2'b10;

    // Entries per async FIFO, power of two
    localparam int FIFO_DEPTH = 4;

    // RAM size in 32-bit words, 1 KiB
    localparam int RAM_WORDS = 256;

    // --------------------------------------------------
    // FIFO payloads
    // --------------------------------------------------
    // Request as seen on the Wishbone side, 71 bits
    typedef struct packed {
        logic [SEL_WIDTH-1:0] sel;
        logic                 write;
        logic [1:0]           width;
        logic [WB_WIDTH-1:0]  addr;   // Word aligned
        logic [WB_WIDTH-1:0]  wdata;  // Already in its lanes
    } req_entry_t;

    // Response back to the core, 37 bits
    typedef struct packed {
        logic                err;
        logic [1:0]          width;
        logic [1:0]          addr_lo;
        logic [WB_WIDTH-1:0] rdata;   // Raw bus word
    } resp_entry_t;

endpackage

`default_nettype wire

// ==== dmem_async_fifo.sv ====
/* Dual-clock FIFO with Gray-coded pointers and registered full/empty.
   Payload type is a parameter; valid/ready on both push and pop sides. */

`default_nettype none
`timescale 1ns/10ps

module dmem_async_fifo #(
    parameter type payload_t = logic [7:0]
) (
    // Write side
    input  logic     wr_clk_i,
    input  logic     wr_rst_n_i,
    input  logic     push_valid_i,
    input  payload_t push_data_i,
    output logic     push_ready_o,
    // Read side
    input  logic     rd_clk_i,
    input  logic     rd_rst_n_i,
    input  logic     pop_ready_i,
    output logic     pop_valid_o,
    output payload_t pop_data_o
);

    localparam int AW = $clog2(dmem_wb_pkg::FIFO_DEPTH);

    // Storage, no reset
    payload_t    mem [dmem_wb_pkg::FIFO_DEPTH];

    // Write domain state
    logic        push;
    logic [AW:0] wr_bin_q;
    logic [AW:0] wr_gray_q;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray_next;
    logic [AW:0] rd_gray_s1_q;
    logic [AW:0] rd_gray_s2_q;
    logic        full_q;

    // Read domain state
    logic        pop;
    logic [AW:0] rd_bin_q;
    logic [AW:0] rd_gray_q;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray_next;
    logic [AW:0] wr_gray_s1_q;
    logic [AW:0] wr_gray_s2_q;
    logic        empty_q;

    // --------------------------------------------------
    // Write clock domain
    // --------------------------------------------------
    assign push         = push_valid_i & ~full_q;
    assign wr_bin_next  = wr_bin_q + (AW+1)'(push);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
    assign push_ready_o = ~full_q;

    // Full held high through reset so no push slips in early
    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            full_q    <= 1'b1;
        end else begin
            wr_bin_q  <= wr_bin_next;
            wr_gray_q <= wr_gray_next;
            // Full when top two bits differ and the rest match
            full_q    <= (wr_gray_next ==
                          {~rd_gray_s2_q[AW:AW-1], rd_gray_s2_q[AW-2:0]});
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (push) begin
            mem[wr_bin_q[AW-1:0]] <= push_data_i;
        end
    end

    // Read pointer into write domain, two flops
    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            rd_gray_s1_q <= '0;
            rd_gray_s2_q <= '0;
        end else begin
            rd_gray_s1_q <= rd_gray_q;
            rd_gray_s2_q <= rd_gray_s1_q;
        end
    end

    // --------------------------------------------------
    // Read clock domain
    // --------------------------------------------------
    assign pop          = pop_ready_i & ~empty_q;
    assign rd_bin_next  = rd_bin_q + (AW+1)'(pop);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;
    assign pop_valid_o  = ~empty_q;
    assign pop_data_o   = mem[rd_bin_q[AW-1:0]];

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
            empty_q   <= 1'b1;
        end else begin
            rd_bin_q  <= rd_bin_next;
            rd_gray_q <= rd_gray_next;
            // Empty once the read pointer catches the synced write pointer
            empty_q   <= (rd_gray_next == wr_gray_s2_q);
        end
    end

    // Write pointer into read domain
    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            wr_gray_s1_q <= '0;
            wr_gray_s2_q <= '0;
        end else begin
            wr_gray_s1_q <= wr_gray_q;
            wr_gray_s2_q <= wr_gray_s1_q;
        end
    end

endmodule

`default_nettype wire

// ==== dmem_wb_bridge.sv ====
/* Core data-memory port to Wishbone master across two clock domains.
   Requests and responses each pass through an async FIFO; lanes steered here. */

`default_nettype none
`timescale 1ns/10ps

module dmem_wb_bridge (
    input  logic                                core_clk_i,
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    // Core side, core_clk_i
    input  logic                                dmem_req_i,
    input  logic                                dmem_cmd_i,
    input  logic [1:0]                          dmem_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_addr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_wdata_i,
    output logic                                dmem_req_ack_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_rdata_o,
    output logic [1:0]                          dmem_resp_o,
    // Wishbone master, wb_clk_i
    output logic                                wbd_stb_o,
    output logic                                wbd_we_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_adr_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_o,
    output logic [dmem_wb_pkg::SEL_WIDTH-1:0]   wbd_sel_o,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_i,
    input  logic                                wbd_ack_i,
    input  logic                                wbd_err_i
);

    localparam int DW = dmem_wb_pkg::WB_WIDTH;
    localparam int SW = dmem_wb_pkg::SEL_WIDTH;

    // Byte selects from width and low address bits
    function automatic logic [SW-1:0] byte_sel(input logic [1:0] width, input logic [1:0] lo);
        case (width)
            dmem_wb_pkg::MEM_WIDTH_BYTE:  return SW'(1) << lo;
            dmem_wb_pkg::MEM_WIDTH_HWORD: return SW'(3) << {lo[1], 1'b0};
            default:                      return '1;
        endcase
    endfunction

    // Recover the low address bits from the lowest set select
    function automatic logic [1:0] sel_to_lo(input logic [SW-1:0] sel);
        if (sel[0]) return 2'd0;
        if (sel[1]) return 2'd1;
        if (sel[2]) return 2'd2;
        return 2'd3;
    endfunction

    // Shift addressed lane down to bit 0 and zero-extend
    function automatic logic [DW-1:0] load_align(input logic [1:0] width, input logic [1:0] lo,
                                                 input logic [DW-1:0] rdata);
        logic [DW-1:0] shifted;
        shifted = rdata >> {lo, 3'b000};
        case (width)
            dmem_wb_pkg::MEM_WIDTH_BYTE:  return {{(DW-8){1'b0}}, shifted[7:0]};
            dmem_wb_pkg::MEM_WIDTH_HWORD: return {{(DW-16){1'b0}}, shifted[15:0]};
            default:                      return rdata;
        endcase
    endfunction

    logic [1:0]               core_rst_q;
    logic [1:0]               wb_rst_q;
    logic                     core_rst_n;
    logic                     wb_rst_n;

    dmem_wb_pkg::req_entry_t  req_push_data;
    dmem_wb_pkg::req_entry_t  req_head;
    logic                     req_head_valid;
    dmem_wb_pkg::resp_entry_t resp_push_data;
    dmem_wb_pkg::resp_entry_t resp_head;
    logic                     resp_push_ready;
    logic                     resp_head_valid;
    logic                     wb_stb;
    logic                     wb_done;

    // --------------------------------------------------
    // Reset release, one synchronizer per domain
    // --------------------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            core_rst_q <= '0;
        end else begin
            core_rst_q <= {core_rst_q[0], 1'b1};
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_rst_q <= '0;
        end else begin
            wb_rst_q <= {wb_rst_q[0], 1'b1};
        end
    end

    assign core_rst_n = core_rst_q[1];
    assign wb_rst_n   = wb_rst_q[1];

    // --------------------------------------------------
    // Request path, core to Wishbone
    // --------------------------------------------------
    assign req_push_data.sel   = byte_sel(dmem_width_i, dmem_addr_i[1:0]);
    assign req_push_data.write = (dmem_cmd_i == dmem_wb_pkg::MEM_CMD_WR);
    assign req_push_data.width = dmem_width_i;
    assign req_push_data.addr  = {dmem_addr_i[DW-1:2], 2'b00};
    // Store data copied into every lane; selects pick the live ones
    assign req_push_data.wdata = (dmem_width_i == dmem_wb_pkg::MEM_WIDTH_BYTE)  ?
                                     {4{dmem_wdata_i[7:0]}} :
                                 (dmem_width_i == dmem_wb_pkg::MEM_WIDTH_HWORD) ?
                                     {2{dmem_wdata_i[15:0]}} : dmem_wdata_i;

    dmem_async_fifo #(
        .payload_t (dmem_wb_pkg::req_entry_t)
    ) req_fifo_i (
        .wr_clk_i     (core_clk_i),
        .wr_rst_n_i   (core_rst_n),
        .push_valid_i (dmem_req_i),
        .push_data_i  (req_push_data),
        .push_ready_o (dmem_req_ack_o),
        .rd_clk_i     (wb_clk_i),
        .rd_rst_n_i   (wb_rst_n),
        .pop_ready_i  (wb_done),
        .pop_valid_o  (req_head_valid),
        .pop_data_o   (req_head)
    );

    // Strobe only when the response has somewhere to go
    assign wb_stb  = req_head_valid & resp_push_ready;
    assign wb_done = wb_stb & wbd_ack_i;

    // Fields forced to zero while idle
    assign wbd_stb_o = wb_stb;
    assign wbd_we_o  = wb_stb & req_head.write;
    assign wbd_adr_o = wb_stb ? req_head.addr  : '0;
    assign wbd_dat_o = wb_stb ? req_head.wdata : '0;
    assign wbd_sel_o = wb_stb ? req_head.sel   : '0;

    // --------------------------------------------------
    // Response path, Wishbone to core
    // --------------------------------------------------
    assign resp_push_data.err     = wbd_err_i;
    assign resp_push_data.width   = req_head.width;
    assign resp_push_data.addr_lo = sel_to_lo(req_head.sel);
    assign resp_push_data.rdata   = req_head.write ? '0 : wbd_dat_i;

    dmem_async_fifo #(
        .payload_t (dmem_wb_pkg::resp_entry_t)
    ) resp_fifo_i (
        .wr_clk_i     (wb_clk_i),
        .wr_rst_n_i   (wb_rst_n),
        .push_valid_i (wb_done),
        .push_data_i  (resp_push_data),
        .push_ready_o (resp_push_ready),
        .rd_clk_i     (core_clk_i),
        .rd_rst_n_i   (core_rst_n),
        .pop_ready_i  (1'b1),
        .pop_valid_o  (resp_head_valid),
        .pop_data_o   (resp_head)
    );

    // Core takes every response the cycle it shows
    assign dmem_resp_o  = !resp_head_valid ? dmem_wb_pkg::MEM_RESP_NOTRDY :
                          resp_head.err    ? dmem_wb_pkg::MEM_RESP_RDY_ER :
                                             dmem_wb_pkg::MEM_RESP_RDY_OK;
    assign dmem_rdata_o = (resp_head_valid & ~resp_head.err) ?
                          load_align(resp_head.width, resp_head.addr_lo, resp_head.rdata) : '0;

endmodule

`default_nettype wire

// ==== wb_data_ram.sv ====
/* Word-organized Wishbone slave RAM with byte selects.
   Single-cycle ack; out-of-range accesses get err and leave memory alone. */

`default_nettype none
`timescale 1ns/10ps

module wb_data_ram (
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    input  logic                                wbd_stb_i,
    input  logic                                wbd_we_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_adr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_i,
    input  logic [dmem_wb_pkg::SEL_WIDTH-1:0]   wbd_sel_i,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_o,
    output logic                                wbd_ack_o,
    output logic                                wbd_err_o
);

    localparam int DW    = dmem_wb_pkg::WB_WIDTH;
    localparam int IDX_W = $clog2(dmem_wb_pkg::RAM_WORDS);

    logic [DW-1:0]    mem [dmem_wb_pkg::RAM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             in_range;
    logic             first_cyc;
    logic             ack_q;
    logic             err_q;
    logic [DW-1:0]    rdata_q;

    assign word_idx  = wbd_adr_i[2 +: IDX_W];
    // Anything at or above RAM_WORDS*4 bytes misses
    assign in_range  = (wbd_adr_i[DW-1:IDX_W+2] == '0);
    // Strobe seen, ack not yet given
    assign first_cyc = wbd_stb_i & ~ack_q;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= first_cyc;
            err_q <= first_cyc & ~in_range;
        end
    end

    assign wbd_ack_o = ack_q;
    assign wbd_err_o = err_q;
    assign wbd_dat_o = ack_q ? rdata_q : '0;

    // --------------------------------------------------
    // Array access
    // --------------------------------------------------
    // Read captured on the first cycle, shown with ack
    always_ff @(posedge wb_clk_i) begin
        if (first_cyc) begin
            rdata_q <= in_range ? mem[word_idx] : '0;
        end
    end

    // Selected bytes written on the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (ack_q & wbd_stb_i & wbd_we_i & ~err_q) begin
            for (int b = 0; b < dmem_wb_pkg::SEL_WIDTH; b++) begin
                if (wbd_sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wbd_dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dmem_wb_top.sv ====
/* Data-memory subsystem top: core-side bridge driving the Wishbone RAM.
   Core signals in core_clk_i, bus and RAM in wb_clk_i. */

`default_nettype none
`timescale 1ns/10ps

module dmem_wb_top (
    input  logic                                core_clk_i,
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    input  logic                                dmem_req_i,
    input  logic                                dmem_cmd_i,
    input  logic [1:0]                          dmem_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_addr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_wdata_i,
    output logic                                dmem_req_ack_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_rdata_o,
    output logic [1:0]                          dmem_resp_o
);

    // Internal Wishbone bus
    logic                               wbd_stb;
    logic                               wbd_we;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]   wbd_adr;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]   wbd_dat_o;
    logic [dmem_wb_pkg::SEL_WIDTH-1:0]  wbd_sel;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]   wbd_dat_i;
    logic                               wbd_ack;
    logic                               wbd_err;

    dmem_wb_bridge dmem_wb_bridge_i (
        .core_clk_i     (core_clk_i),
        .wb_clk_i       (wb_clk_i),
        .arst_n_i       (arst_n_i),
        .dmem_req_i     (dmem_req_i),
        .dmem_cmd_i     (dmem_cmd_i),
        .dmem_width_i   (dmem_width_i),
        .dmem_addr_i    (dmem_addr_i),
        .dmem_wdata_i   (dmem_wdata_i),
        .dmem_req_ack_o (dmem_req_ack_o),
        .dmem_rdata_o   (dmem_rdata_o),
        .dmem_resp_o    (dmem_resp_o),
        .wbd_stb_o      (wbd_stb),
        .wbd_we_o       (wbd_we),
        .wbd_adr_o      (wbd_adr),
        .wbd_dat_o      (wbd_dat_o),
        .wbd_sel_o      (wbd_sel),
        .wbd_dat_i      (wbd_dat_i),
        .wbd_ack_i      (wbd_ack),
        .wbd_err_i      (wbd_err)
    );

    // Slave side, master data out is slave data in
    wb_data_ram wb_data_ram_i (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .wbd_stb_i (wbd_stb),
        .wbd_we_i  (wbd_we),
        .wbd_adr_i (wbd_adr),
        .wbd_dat_i (wbd_dat_o),
        .wbd_sel_i (wbd_sel),
        .wbd_dat_o (wbd_dat_i),
        .wbd_ack_o (wbd_ack),
        .wbd_err_o (wbd_err)
    );

endmodule

`default_nettype wire

// ==== dmem_wb_assertions.sv ====
/* Protocol checks bound into the data-memory top level.
   Watches the internal Wishbone bus and the core response code. */

`default_nettype none
`timescale 1ns/10ps

module dmem_wb_assertions (
    input  logic                              core_clk_i,
    input  logic                              wb_clk_i,
    input  logic                              arst_n_i,
    input  logic                              wbd_stb_i,
    input  logic                              wbd_we_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]  wbd_adr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]  wbd_dat_i,
    input  logic [dmem_wb_pkg::SEL_WIDTH-1:0] wbd_sel_i,
    input  logic                              wbd_ack_i,
    input  logic [1:0]                        dmem_resp_i
);

    // Slave ack lasts one cycle
    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wbd_ack_i |=> !wbd_ack_i)
        else $error("wbd_ack high on two cycles in a row");

    // Master holds the access until ack
    req_held_until_ack: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (wbd_stb_i && !wbd_ack_i) |=> (wbd_stb_i && $stable(wbd_we_i) && $stable(wbd_adr_i)
                                       && $stable(wbd_dat_i) && $stable(wbd_sel_i)))
        else $error("Wishbone request changed before ack");

    // Only the three defined response codes
    resp_code_legal: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
        (dmem_resp_i == dmem_wb_pkg::MEM_RESP_NOTRDY) ||
        (dmem_resp_i == dmem_wb_pkg::MEM_RESP_RDY_OK) ||
        (dmem_resp_i == dmem_wb_pkg::MEM_RESP_RDY_ER))
        else $error("undefined response code on dmem_resp_o");

endmodule

bind dmem_wb_top dmem_wb_assertions dmem_wb_assertions_i (
    .core_clk_i  (core_clk_i),
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .wbd_stb_i   (wbd_stb),
    .wbd_we_i    (wbd_we),
    .wbd_adr_i   (wbd_adr),
    .wbd_dat_i   (wbd_dat_o),
    .wbd_sel_i   (wbd_sel),
    .wbd_ack_i   (wbd_ack),
    .dmem_resp_i (dmem_resp_o)
);

`default_nettype wire

// ==== dmem_wb_tb.sv ====
/* Testbench for the data-memory Wishbone port: table of directed accesses,
   then back-to-back random traffic checked against a byte-array memory model. */

`default_nettype none
`timescale 1ns/10ps

module dmem_wb_tb;

    // Short names for the package codes used in the table
    localparam logic       RD   = dmem_wb_pkg::MEM_CMD_RD;
    localparam logic       WR   = dmem_wb_pkg::MEM_CMD_WR;
    localparam logic [1:0] W_B  = dmem_wb_pkg::MEM_WIDTH_BYTE;
    localparam logic [1:0] W_H  = dmem_wb_pkg::MEM_WIDTH_HWORD;
    localparam logic [1:0] W_W  = dmem_wb_pkg::MEM_WIDTH_WORD;
    localparam logic [1:0] R_NR = dmem_wb_pkg::MEM_RESP_NOTRDY;
    localparam logic [1:0] R_OK = dmem_wb_pkg::MEM_RESP_RDY_OK;
    localparam logic [1:0] R_ER = dmem_wb_pkg::MEM_RESP_RDY_ER;

    localparam int N_VEC   = 23;
    localparam int N_INIT  = 16;    // Word stores that fill the random window
    localparam int N_RAND  = 64;
    localparam int N_TOTAL = N_VEC + N_INIT + N_RAND;
    localparam int WATCHDOG_CYCLES = 400 * N_TOTAL;
    localparam logic [31:0] RAND_BASE = 32'h0000_0100;

    typedef struct packed {
        logic        cmd;
        logic [1:0]  width;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  resp;
        logic [31:0] rdata;
    } vec_t;

    logic        core_clk_i;
    logic        wb_clk_i;
    logic        arst_n_i;
    logic        dmem_req_i;
    logic        dmem_cmd_i;
    logic [1:0]  dmem_width_i;
    logic [31:0] dmem_addr_i;
    logic [31:0] dmem_wdata_i;
    logic        dmem_req_ack_o;
    logic [31:0] dmem_rdata_o;
    logic [1:0]  dmem_resp_o;

    // Expected results written at issue and read back in order
    string       exp_name  [N_TOTAL];
    logic [1:0]  exp_resp  [N_TOTAL];
    logic [31:0] exp_rdata [N_TOTAL];
    int          issued_count = 0;
    int          resp_count   = 0;
    int          full_waits   = 0;

    // Reference memory with one entry per in-range byte address
    logic [7:0]  ref_mem [1024];

    // --------------------------------------------------
    // Directed table
    // --------------------------------------------------
    vec_t vec_table [N_VEC] = '{
        '{WR, W_W, 32'h0000_0010, 32'hdead_beef, R_OK, 32'h0000_0000},
        '{RD, W_W, 32'h0000_0010, 32'h0000_0000, R_OK, 32'hdead_beef},
        '{WR, W_W, 32'h0000_0020, 32'h1122_3344, R_OK, 32'h0000_0000},
        '{WR, W_B, 32'h0000_0021, 32'h0000_00a5, R_OK, 32'h0000_0000},
        '{WR, W_H, 32'h0000_0022, 32'h0000_5a6b, R_OK, 32'h0000_0000},
        '{RD, W_W, 32'h0000_0020, 32'h0000_0000, R_OK, 32'h5a6b_a544},
        '{RD, W_B, 32'h0000_0021, 32'h0000_0000, R_OK, 32'h0000_00a5},
        '{RD, W_B, 32'h0000_0023, 32'h0000_0000, R_OK, 32'h0000_005a},
        '{RD, W_H, 32'h0000_0022, 32'h0000_0000, R_OK, 32'h0000_5a6b},
        '{RD, W_H, 32'h0000_0020, 32'h0000_0000, R_OK, 32'h0000_a544},
        '{RD, W_B, 32'h0000_0020, 32'h0000_0000, R_OK, 32'h0000_0044},
        '{WR, W_W, 32'h0000_0030, 32'h0000_0000, R_OK, 32'h0000_0000},
        '{WR, W_B, 32'h0000_0033, 32'h1234_56c3, R_OK, 32'h0000_0000},
        '{WR, W_H, 32'h0000_0030, 32'hffff_8001, R_OK, 32'h0000_0000},
        '{RD, W_W, 32'h0000_0030, 32'h0000_0000, R_OK, 32'hc300_8001},
        '{RD, W_H, 32'h0000_0030, 32'h0000_0000, R_OK, 32'h0000_8001},
        '{RD, W_B, 32'h0000_0033, 32'h0000_0000, R_OK, 32'h0000_00c3},
        // Accesses past the end alias 0x10 and 0x21, which must stay untouched
        '{WR, W_W, 32'h0000_0410, 32'h0bad_f00d, R_ER, 32'h0000_0000},
        '{WR, W_B, 32'h0000_0421, 32'h0000_0077, R_ER, 32'h0000_0000},
        '{RD, W_W, 32'h0000_0400, 32'h0000_0000, R_ER, 32'h0000_0000},
        '{RD, W_B, 32'hffff_fff0, 32'h0000_0000, R_ER, 32'h0000_0000},
        '{RD, W_W, 32'h0000_0010, 32'h0000_0000, R_OK, 32'hdead_beef},
        '{RD, W_W, 32'h0000_0020, 32'h0000_0000, R_OK, 32'h5a6b_a544}
    };

    string vec_name [N_VEC] = '{
        "word store", "word load", "word store base", "byte store lane 1",
        "hword store upper", "merged word load", "byte load lane 1", "byte load lane 3",
        "hword load upper", "hword load lower", "byte load lane 0", "word clear",
        "byte store lane 3", "hword store lower", "merged word load 2", "hword zero extend",
        "byte zero extend", "store past end", "byte store past end", "load past end",
        "byte load top", "word unchanged", "merged unchanged"
    };

    dmem_wb_top dmem_wb_top_i (
        .core_clk_i     (core_clk_i),
        .wb_clk_i       (wb_clk_i),
        .arst_n_i       (arst_n_i),
        .dmem_req_i     (dmem_req_i),
        .dmem_cmd_i     (dmem_cmd_i),
        .dmem_width_i   (dmem_width_i),
        .dmem_addr_i    (dmem_addr_i),
        .dmem_wdata_i   (dmem_wdata_i),
        .dmem_req_ack_o (dmem_req_ack_o),
        .dmem_rdata_o   (dmem_rdata_o),
        .dmem_resp_o    (dmem_resp_o)
    );

    // Unrelated clock periods of 20 ns and 26 ns
    initial begin
        core_clk_i = 1'b0;
        forever #10 core_clk_i = ~core_clk_i;
    end

    initial begin
        wb_clk_i = 1'b0;
        forever #13 wb_clk_i = ~wb_clk_i;
    end

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic end_in_failure();
        $display("Checks failed");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", test, exp, act);
        end_in_failure();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        end_in_failure();
    endtask

    // --------------------------------------------------
    // Stimulus helpers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int width_bytes(input logic [1:0] width);
        if (width == W_B) return 1;
        if (width == W_H) return 2;
        return 4;
    endfunction

    // Little endian with the low data byte at addr
    task automatic ref_store(input logic [31:0] addr, input logic [1:0] width,
                             input logic [31:0] wdata);
        for (int b = 0; b < width_bytes(width); b++) begin
            ref_mem[addr[9:0] + 10'(b)] = wdata[8*b +: 8];
        end
    endtask

    // Zero-extended load
    function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [1:0] width);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < width_bytes(width); b++) begin
            value[8*b +: 8] = ref_mem[addr[9:0] + 10'(b)];
        end
        return value;
    endfunction

    // Called on a falling edge; returns one falling edge after acceptance
    task automatic issue_req(input string name, input logic cmd, input logic [1:0] width,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [1:0] resp, input logic [31:0] rdata);
        exp_name[issued_count]  = name;
        exp_resp[issued_count]  = resp;
        exp_rdata[issued_count] = rdata;
        issued_count++;
        dmem_req_i   = 1'b1;
        dmem_cmd_i   = cmd;
        dmem_width_i = width;
        dmem_addr_i  = addr;
        dmem_wdata_i = wdata;
        // Ack only moves on a rising edge, so its value here decides the next one
        while (!dmem_req_ack_o) begin
            full_waits++;
            @(negedge core_clk_i);
        end
        @(negedge core_clk_i);
        dmem_req_i = 1'b0;
    endtask

    task automatic wait_all_responses();
        while (resp_count != issued_count) begin
            @(negedge core_clk_i);
        end
    endtask

    // --------------------------------------------------
    // Response monitor counting one response per non-NOTRDY cycle
    // --------------------------------------------------
    always @(negedge core_clk_i) begin
        if (arst_n_i) begin
            if (dmem_resp_o == R_NR) begin
                assert (dmem_rdata_o == '0)
                    else report_mismatch("idle read data", 32'h0, dmem_rdata_o);
            end else if (resp_count >= issued_count) begin
                report_problem("response arrived with no request outstanding");
            end else begin
                assert (dmem_resp_o == exp_resp[resp_count])
                    else report_mismatch({exp_name[resp_count], " response"},
                                         32'(exp_resp[resp_count]), 32'(dmem_resp_o));
                assert (dmem_rdata_o == exp_rdata[resp_count])
                    else report_mismatch({exp_name[resp_count], " read data"},
                                         exp_rdata[resp_count], dmem_rdata_o);
                resp_count++;
            end
        end
    end

    // Run limit scaled by request count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk_i);
        report_problem($sformatf("timeout, run exceeded %0d core cycles", WATCHDOG_CYCLES));
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] rng;
        logic        cmd;
        logic [1:0]  width;
        logic [1:0]  lo;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          ack_wait;

        arst_n_i     = 1'b0;
        dmem_req_i   = 1'b0;
        dmem_cmd_i   = RD;
        dmem_width_i = W_W;
        dmem_addr_i  = '0;
        dmem_wdata_i = '0;
        rng          = 32'hbf70_8b30;

        // Reset for two core cycles
        repeat (2) @(posedge core_clk_i);
        @(negedge core_clk_i);
        assert (!dmem_req_ack_o) else report_problem("request ack high during reset");
        assert (dmem_resp_o == R_NR)
            else report_mismatch("reset response", 32'(R_NR), 32'(dmem_resp_o));
        arst_n_i = 1'b1;

        // Ack rises once the core-side synchronizer lets go
        ack_wait = 0;
        while (!dmem_req_ack_o) begin
            assert (ack_wait < 10) else report_problem("request ack never rose after reset");
            ack_wait++;
            @(negedge core_clk_i);
        end

        // Directed table with one request at a time
        for (int i = 0; i < N_VEC; i++) begin
            issue_req(vec_name[i], vec_table[i].cmd, vec_table[i].width, vec_table[i].addr,
                      vec_table[i].wdata, vec_table[i].resp, vec_table[i].rdata);
            wait_all_responses();
        end

        // Fill the random window so every later load has known data
        for (int i = 0; i < N_INIT; i++) begin
            rng  = xorshift32(rng);
            addr = RAND_BASE + 32'(i * 4);
            ref_store(addr, W_W, rng);
            issue_req($sformatf("window fill %0d", i), WR, W_W, addr, rng, R_OK, 32'h0);
        end

        // Back-to-back random traffic
        full_waits = 0;
        for (int i = 0; i < N_RAND; i++) begin
            rng   = xorshift32(rng);
            cmd   = rng[0];
            width = (rng[2:1] == 2'd0) ? W_B : (rng[2:1] == 2'd1) ? W_H : W_W;
            lo    = (width == W_B) ? rng[4:3] : (width == W_H) ? {rng[4], 1'b0} : 2'b00;
            addr  = RAND_BASE + {26'd0, rng[11:8], lo};
            // About one in sixteen goes past the end of the RAM
            if (rng[15:12] == 4'd0) begin
                addr = addr + 32'h0000_0400;
            end
            rng   = xorshift32(rng);
            wdata = rng;
            if (addr >= 32'h0000_0400) begin
                issue_req($sformatf("random %0d", i), cmd, width, addr, wdata, R_ER, 32'h0);
            end else if (cmd == WR) begin
                ref_store(addr, width, wdata);
                issue_req($sformatf("random %0d", i), cmd, width, addr, wdata, R_OK, 32'h0);
            end else begin
                issue_req($sformatf("random %0d", i), cmd, width, addr, wdata, R_OK,
                          ref_load(addr, width));
            end
        end
        wait_all_responses();
        assert (full_waits > 0) else report_problem("request FIFO never filled in random phase");

        // Any stray response in these cycles stops the run in the monitor
        repeat (4) @(negedge core_clk_i);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dmem_wb.f ====
dmem_wb_pkg.sv
dmem_async_fifo.sv
dmem_wb_bridge.sv
wb_data_ram.sv
dmem_wb_top.sv
dmem_wb_assertions.sv
dmem_wb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the data-memory Wishbone testbench with Verilator and run it.
# The run counts as passing only when its output holds the pass message.

cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing --assert \
              -f dmem_wb.f --top-module dmem_wb_tb \
              -o dmem_wb_sim 2>&1 \
          && ./obj_dir/dmem_wb_sim 2>&1)

echo "$sim_out"

echo "$sim_out" | grep -q "All checks passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
